//--- uart_pkg.sv
package uart_pkg;

    // bus geometry
    localparam int DATA_WIDTH = 32;
    localparam int ADDR_WIDTH = 32;
    localparam int BE_WIDTH   = DATA_WIDTH / 8;

    // fifo sizing
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

    localparam int BAUD_WIDTH = 16; // bit period is divisor + 1 clocks

    // register map, byte offsets
    localparam logic [ADDR_WIDTH-1:0] ADDR_BAUD_L   = 32'h0000_0000;
    localparam logic [ADDR_WIDTH-1:0] ADDR_BAUD_H   = 32'h0000_0004;
    localparam logic [ADDR_WIDTH-1:0] ADDR_STATUS   = 32'h0000_0008;
    localparam logic [ADDR_WIDTH-1:0] ADDR_DATA     = 32'h0000_000c;
    localparam logic [ADDR_WIDTH-1:0] ADDR_INT_EN   = 32'h0000_0010;
    localparam logic [ADDR_WIDTH-1:0] ADDR_INT_PEND = 32'h0000_0014;

    // interrupt sources
    localparam int INT_NUM      = 2;
    localparam int INT_RX_READY = 0;
    localparam int INT_TX_EMPTY = 1;

    // host request, held stable while req is high
    typedef struct packed {
        logic                  req;
        logic                  wr;
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] wdata;
        logic [BE_WIDTH-1:0]   be;
    } bus_req_t;

    typedef struct packed {
        logic                  ack;
        logic                  err; // only meaningful with ack
        logic [DATA_WIDTH-1:0] rdata;
    } bus_rsp_t;

    typedef enum logic [1:0] {
        ST_ISSUE,
        ST_RETIRE,
        ST_DONE
    } ctrl_state_e;

    typedef enum logic [1:0] {
        LN_IDLE,
        LN_START,
        LN_DATA,
        LN_STOP
    } line_state_e;

endpackage

//--- uart_fifo.sv
`timescale 1ns/10ps

module uart_fifo
    import uart_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       i_push,
    input  logic [7:0] i_data,
    input  logic       i_pop,
    output logic [7:0] o_data,
    output logic       o_full,
    output logic       o_empty
);

    logic [7:0]            mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_CNT_W-1:0] count;
    logic                  do_push;
    logic                  do_pop;

    assign do_push = i_push & ~o_full;  // push into a full fifo is lost
    assign do_pop  = i_pop & ~o_empty;
    assign o_full  = (count == FIFO_CNT_W'(FIFO_DEPTH));
    assign o_empty = (count == '0);
    assign o_data  = mem[rd_ptr];       // head byte, valid when not empty

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= i_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // both or neither
            endcase
        end
    end

endmodule

//--- uart_tx.sv
`timescale 1ns/10ps

module uart_tx
    import uart_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [BAUD_WIDTH-1:0] i_baud_div,
    input  logic                  i_fifo_empty,
    input  logic [7:0]            i_fifo_data,
    output logic                  o_fifo_pop,
    output logic                  o_tx
);

    line_state_e           state;
    logic [BAUD_WIDTH-1:0] cnt;        // clocks into current bit
    logic [2:0]            bit_idx;
    logic [7:0]            shift;
    logic                  bit_end;

    assign bit_end = (cnt == i_baud_div);

    // take the head byte on the edge that leaves idle
    assign o_fifo_pop = (state == LN_IDLE) & ~i_fifo_empty;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= LN_IDLE;
            cnt     <= '0;
            bit_idx <= '0;
            o_tx    <= 1'b1;            // line idles high
        end else begin
            cnt <= bit_end ? '0 : cnt + 1'b1;
            case (state)
                LN_IDLE: begin
                    cnt <= '0;
                    if (!i_fifo_empty) begin
                        o_tx  <= 1'b0;  // start bit
                        state <= LN_START;
                    end
                end
                LN_START: begin
                    if (bit_end) begin
                        o_tx    <= shift[0];
                        bit_idx <= '0;
                        state   <= LN_DATA;
                    end
                end
                LN_DATA: begin
                    if (bit_end) begin
                        if (bit_idx == 3'd7) begin
                            o_tx  <= 1'b1;  // stop bit
                            state <= LN_STOP;
                        end else begin
                            o_tx    <= shift[0];
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end
                end
                LN_STOP: begin
                    if (bit_end) begin
                        state <= LN_IDLE;
                    end
                end
                default: state <= LN_IDLE;
            endcase
        end
    end

    // shift register, lsb first
    always_ff @(posedge clk) begin
        if (o_fifo_pop) begin
            shift <= i_fifo_data;
        end else if (bit_end && (state == LN_START || state == LN_DATA)) begin
            shift <= {1'b0, shift[7:1]};
        end
    end

endmodule

//--- uart_rx.sv
`timescale 1ns/10ps

module uart_rx
    import uart_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [BAUD_WIDTH-1:0] i_baud_div,
    input  logic                  i_rx,
    input  logic                  i_fifo_full,
    output logic                  o_push,
    output logic [7:0]            o_byte,
    output logic                  o_overrun
);

    line_state_e           state;
    logic                  rx_meta;
    logic                  rx_sync;
    logic                  rx_prev;    // for the start edge
    logic [BAUD_WIDTH-1:0] cnt;
    logic [2:0]            bit_idx;
    logic [7:0]            shift;
    logic                  bit_end;
    logic                  half_bit;

    assign bit_end  = (cnt == i_baud_div);
    assign half_bit = (cnt == {1'b0, i_baud_div[BAUD_WIDTH-1:1]});
    assign o_byte   = shift;        // stable until the next frame shifts in

    // two flops on the async pin
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= i_rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= LN_IDLE;
            cnt       <= '0;
            bit_idx   <= '0;
            o_push    <= 1'b0;
            o_overrun <= 1'b0;
        end else begin
            o_push    <= 1'b0;
            o_overrun <= 1'b0;
            cnt       <= cnt + 1'b1;
            case (state)
                LN_IDLE: begin
                    cnt <= '0;
                    if (rx_prev && !rx_sync) begin
                        state <= LN_START;  // falling edge seen
                    end
                end
                LN_START: begin
                    if (half_bit) begin
                        cnt <= '0;          // now aligned to bit centres
                        if (!rx_sync) begin
                            bit_idx <= '0;
                            state   <= LN_DATA;
                        end else begin
                            state <= LN_IDLE;   // glitch, not a start bit
                        end
                    end
                end
                LN_DATA: begin
                    if (bit_end) begin
                        cnt <= '0;
                        if (bit_idx == 3'd7) begin
                            state <= LN_STOP;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end
                end
                LN_STOP: begin
                    if (bit_end) begin
                        cnt   <= '0;
                        state <= LN_IDLE;
                        if (rx_sync) begin  // framing error drops the byte
                            o_push    <= ~i_fifo_full;
                            o_overrun <= i_fifo_full;
                        end
                    end
                end
                default: state <= LN_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == LN_DATA && bit_end) begin
            shift <= {rx_sync, shift[7:1]};
        end
    end

endmodule

//--- uart_bus_ctrl.sv
`timescale 1ns/10ps

module uart_bus_ctrl
    import uart_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  bus_req_t              i_bus,
    input  logic                  i_tx_full,
    input  logic                  i_tx_empty,
    input  logic                  i_rx_empty,
    input  logic [7:0]            i_rx_data,
    input  logic                  i_overrun,
    output bus_rsp_t              o_bus,
    output logic                  o_irq,
    output logic [BAUD_WIDTH-1:0] o_baud_div,
    output logic                  o_tx_push,
    output logic [7:0]            o_tx_data,
    output logic                  o_rx_pop
);

    ctrl_state_e           state;
    logic                  ack_q;
    logic                  err_q;
    logic [DATA_WIDTH-1:0] rdata_q;
    logic [BAUD_WIDTH-1:0] baud_div;
    logic [INT_NUM-1:0]    int_en;
    logic [INT_NUM-1:0]    int_pend;
    logic                  overrun_q;  // sticky until status read
    logic                  rx_rdy_prev;
    logic                  tx_empty_prev;

    logic                  addr_ok;
    logic                  access_err;
    logic                  issue;
    logic                  wr_hit;
    logic                  rd_hit;
    logic [DATA_WIDTH-1:0] rd_data;
    logic [INT_NUM-1:0]    pend_set;
    logic [INT_NUM-1:0]    pend_clr;
    logic                  ovr_clr;

    assign o_bus      = '{ack: ack_q, err: err_q, rdata: rdata_q};
    assign o_baud_div = baud_div;
    assign o_irq      = |(int_pend & int_en);

    // read mux and address check
    always_comb begin
        addr_ok = 1'b1;
        rd_data = '0;
        case (i_bus.addr)
            ADDR_BAUD_L: begin
                if (i_bus.be[1]) begin
                    rd_data = DATA_WIDTH'(baud_div);
                end else begin
                    rd_data = DATA_WIDTH'(baud_div[7:0]);
                end
            end
            ADDR_BAUD_H:   rd_data = DATA_WIDTH'(baud_div[15:8]);
            ADDR_STATUS:   rd_data = DATA_WIDTH'({overrun_q, i_tx_full, ~i_rx_empty});
            ADDR_DATA:     rd_data = i_rx_empty ? '0 : DATA_WIDTH'(i_rx_data);
            ADDR_INT_EN:   rd_data = DATA_WIDTH'(int_en);
            ADDR_INT_PEND: rd_data = DATA_WIDTH'(int_pend);
            default:       addr_ok = 1'b0;
        endcase
    end

    assign access_err = ~i_bus.be[0] | ~addr_ok;    // byte lane 0 is mandatory
    assign issue      = (state == ST_ISSUE) & i_bus.req & ~access_err;
    assign wr_hit     = issue & i_bus.wr;
    assign rd_hit     = issue & ~i_bus.wr;

    // interrupt sources fire on rising edges only
    always_comb begin
        pend_set               = '0;
        pend_set[INT_RX_READY] = ~i_rx_empty & ~rx_rdy_prev;
        pend_set[INT_TX_EMPTY] = i_tx_empty & ~tx_empty_prev;
        pend_clr               = '0;
        if (wr_hit && i_bus.addr == ADDR_INT_PEND) begin
            pend_clr = i_bus.wdata[INT_NUM-1:0];    // write 1 to clear
        end
        ovr_clr = rd_hit & (i_bus.addr == ADDR_STATUS);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state         <= ST_ISSUE;
            ack_q         <= 1'b0;
            err_q         <= 1'b0;
            rdata_q       <= '0;
            baud_div      <= '0;
            int_en        <= '0;
            int_pend      <= '0;
            overrun_q     <= 1'b0;
            rx_rdy_prev   <= 1'b0;
            tx_empty_prev <= 1'b1;      // fifo comes out of reset empty
            o_tx_push     <= 1'b0;
            o_rx_pop      <= 1'b0;
        end else begin
            o_tx_push     <= 1'b0;
            o_rx_pop      <= 1'b0;
            rx_rdy_prev   <= ~i_rx_empty;
            tx_empty_prev <= i_tx_empty;
            // a new event wins over a clear in the same cycle
            int_pend      <= (int_pend & ~pend_clr) | pend_set;
            overrun_q     <= (overrun_q & ~ovr_clr) | i_overrun;

            case (state)
                ST_ISSUE: begin
                    if (i_bus.req) begin
                        if (access_err) begin
                            ack_q <= 1'b1;  // fast error response
                            err_q <= 1'b1;
                            state <= ST_DONE;
                        end else begin
                            rdata_q <= i_bus.wr ? rdata_q : rd_data;
                            state   <= ST_RETIRE;
                        end
                    end
                end
                ST_RETIRE: begin
                    ack_q <= 1'b1;
                    state <= ST_DONE;
                end
                ST_DONE: begin
                    if (!i_bus.req) begin
                        ack_q <= 1'b0;
                        err_q <= 1'b0;
                        state <= ST_ISSUE;
                    end
                end
                default: state <= ST_ISSUE;
            endcase

            if (wr_hit) begin
                case (i_bus.addr)
                    ADDR_BAUD_L: begin
                        if (i_bus.be[1]) begin
                            baud_div <= i_bus.wdata[15:0];
                        end else begin
                            baud_div[7:0] <= i_bus.wdata[7:0];
                        end
                    end
                    ADDR_BAUD_H: baud_div[15:8] <= i_bus.wdata[7:0];
                    ADDR_DATA:   o_tx_push <= ~i_tx_full;  // dropped when full
                    ADDR_INT_EN: int_en <= i_bus.wdata[INT_NUM-1:0];
                    default:     ;  // status is read only, pend handled above
                endcase
            end

            if (rd_hit && i_bus.addr == ADDR_DATA) begin
                o_rx_pop <= ~i_rx_empty;
            end
        end
    end

    // byte for the transmit fifo, qualified by o_tx_push
    always_ff @(posedge clk) begin
        if (wr_hit && i_bus.addr == ADDR_DATA) begin
            o_tx_data <= i_bus.wdata[7:0];
        end
    end

endmodule

//--- uart_periph.sv
`timescale 1ns/10ps

module uart_periph
    import uart_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  bus_req_t i_bus,
    input  logic     i_rx,
    output bus_rsp_t o_bus,
    output logic     o_irq,
    output logic     o_tx
);

    logic [BAUD_WIDTH-1:0] baud_div;
    logic                  tx_push;
    logic [7:0]            tx_wdata;
    logic                  tx_pop;
    logic [7:0]            tx_head;
    logic                  tx_full;
    logic                  tx_empty;
    logic                  rx_push;
    logic [7:0]            rx_byte;
    logic                  rx_pop;
    logic [7:0]            rx_head;
    logic                  rx_full;
    logic                  rx_empty;
    logic                  overrun;

    uart_bus_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_bus      (i_bus),
        .i_tx_full  (tx_full),
        .i_tx_empty (tx_empty),
        .i_rx_empty (rx_empty),
        .i_rx_data  (rx_head),
        .i_overrun  (overrun),
        .o_bus      (o_bus),
        .o_irq      (o_irq),
        .o_baud_div (baud_div),
        .o_tx_push  (tx_push),
        .o_tx_data  (tx_wdata),
        .o_rx_pop   (rx_pop)
    );

    uart_fifo tx_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_push  (tx_push),
        .i_data  (tx_wdata),
        .i_pop   (tx_pop),
        .o_data  (tx_head),
        .o_full  (tx_full),
        .o_empty (tx_empty)
    );

    uart_fifo rx_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_push  (rx_push),
        .i_data  (rx_byte),
        .i_pop   (rx_pop),
        .o_data  (rx_head),
        .o_full  (rx_full),
        .o_empty (rx_empty)
    );

    uart_tx u_tx (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_baud_div   (baud_div),
        .i_fifo_empty (tx_empty),
        .i_fifo_data  (tx_head),
        .o_fifo_pop   (tx_pop),
        .o_tx         (o_tx)
    );

    uart_rx u_rx (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_baud_div  (baud_div),
        .i_rx        (i_rx),
        .i_fifo_full (rx_full),
        .o_push      (rx_push),
        .o_byte      (rx_byte),
        .o_overrun   (overrun)
    );

endmodule

//--- tb_uart_periph.sv
`timescale 1ns/10ps

module tb_uart_periph
    import uart_pkg::*;
();

    localparam int CLK_PERIOD    = 10;
    localparam int DIV           = 3;
    localparam int BIT_CYCLES    = DIV + 1;
    localparam int FRAME_CYCLES  = 10 * BIT_CYCLES;     // 8N1
    localparam int N_BURST       = 6;
    localparam int N_FRAMES      = 3 + 2 + FIFO_DEPTH + 1;  // frames of loopback, irq and burst
    localparam int MARGIN_CYCLES = 1000;                // bus traffic and quiet wait
    localparam int TIMEOUT_NS    = (N_FRAMES * FRAME_CYCLES + MARGIN_CYCLES) * CLK_PERIOD;

    logic        clk;
    logic        rst_n;
    bus_req_t    bus_req;
    bus_rsp_t    bus_rsp;
    logic        irq;
    logic        tx_line;   // o_tx fed back into i_rx
    logic [31:0] seed;

    uart_periph UUT (
        .clk   (clk),
        .rst_n (rst_n),
        .i_bus (bus_req),
        .i_rx  (tx_line),
        .o_bus (bus_rsp),
        .o_irq (irq),
        .o_tx  (tx_line)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // start bit plus any low data bits right after it
    function automatic int start_low_bits(input logic [7:0] b);
        int   n;
        logic run;
        n   = 1;
        run = 1'b1;
        for (int i = 0; i < 8; i++) begin
            if (run && !b[i]) begin
                n = n + 1;
            end else begin
                run = 1'b0;
            end
        end
        return n;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            report_failure($sformatf("Fail %s: expected 0x%0h, actual 0x%0h", name, exp, act));
        end
    endtask

    task automatic next_byte(output logic [7:0] b);
        seed = xorshift32(seed);
        b    = seed[7:0];
    endtask

    // four-phase access that also checks the ack latency
    task automatic bus_access(input logic wr, input logic [31:0] addr,
                              input logic [31:0] wdata, input logic [3:0] be,
                              input logic exp_err,
                              output logic [31:0] rdata, output logic err);
        int lat;
        lat = 0;
        @(negedge clk);
        bus_req = '{req: 1'b1, wr: wr, addr: addr, wdata: wdata, be: be};
        do begin
            @(negedge clk);
            lat = lat + 1;
        end while (!bus_rsp.ack);
        rdata = bus_rsp.rdata;
        err   = bus_rsp.err;
        check_value("ack latency", exp_err ? 32'd1 : 32'd2, 32'(lat));
        bus_req.req = 1'b0;
        do begin
            @(negedge clk);
        end while (bus_rsp.ack);
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] wdata,
                             input logic [3:0] be);
        logic [31:0] rd;
        logic        err;
        bus_access(1'b1, addr, wdata, be, 1'b0, rd, err);
        check_value("write err", 32'd0, 32'(err));
    endtask

    task automatic bus_read(input logic [31:0] addr, input logic [3:0] be,
                            output logic [31:0] rdata);
        logic err;
        bus_access(1'b0, addr, 32'd0, be, 1'b0, rdata, err);
        check_value("read err", 32'd0, 32'(err));
    endtask

    task automatic wait_rx_ready();
        logic [31:0] st;
        do begin
            bus_read(ADDR_STATUS, 4'b0001, st);
        end while (!st[0]);
    endtask

    task automatic measure_low(output int cycles);
        cycles = 0;
        do begin
            @(negedge clk);
        end while (tx_line);
        while (!tx_line) begin
            cycles = cycles + 1;
            @(negedge clk);
        end
    endtask

    task automatic wait_line_quiet(input int cycles);
        int run;
        run = 0;
        while (run < cycles) begin
            @(negedge clk);
            run = tx_line ? run + 1 : 0;
        end
    endtask

    initial begin
        #(TIMEOUT_NS);
        report_failure("Timeout: the tests did not finish within the expected time");
    end

    initial begin
        logic [31:0] rd;
        logic [31:0] exp;
        logic        err;
        logic [15:0] baud;
        logic [7:0]  b;
        logic [7:0]  sent [$];
        int          low;
        int          n_accept;
        int          n_kept;
        time         t0;

        clk     = 1'b0;
        rst_n   = 1'b0;
        bus_req = '0;
        seed    = 32'h3a28;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        repeat (2 * BIT_CYCLES) begin
            @(negedge clk);
            check_value("tx idle after reset", 32'd1, 32'(tx_line));
        end
        check_value("irq after reset", 32'd0, 32'(irq));

        // baud register halves and byte-only write
        seed = xorshift32(seed);
        baud = seed[15:0];
        bus_write(ADDR_BAUD_L, {16'h0, baud}, 4'b0011);
        bus_read(ADDR_BAUD_L, 4'b0011, rd);
        check_value("baud_l read", {16'h0, baud}, rd);
        bus_read(ADDR_BAUD_H, 4'b0001, rd);
        check_value("baud_h read", {24'h0, baud[15:8]}, rd);
        bus_write(ADDR_BAUD_L, {24'h0, ~baud[7:0]}, 4'b0001);
        bus_read(ADDR_BAUD_L, 4'b0011, rd);
        check_value("baud_l byte write", {16'h0, baud[15:8], ~baud[7:0]}, rd);

        // error responses
        bus_access(1'b0, ADDR_STATUS, 32'd0, 4'b0010, 1'b1, rd, err);
        check_value("err with be0 low", 32'd1, 32'(err));
        bus_access(1'b1, 32'h0000_0040, 32'd1, 4'b1111, 1'b1, rd, err);
        check_value("err on unmapped", 32'd1, 32'(err));
        bus_read(ADDR_INT_EN, 4'b0001, rd);
        check_value("int_en after errors", 32'd0, rd);

        // loopback of three bytes
        bus_write(ADDR_BAUD_L, 32'(DIV), 4'b0011);
        for (int i = 0; i < 3; i++) begin
            next_byte(b);
            sent.push_back(b);
        end
        fork
            measure_low(low);
            bus_write(ADDR_DATA, {24'h0, sent[0]}, 4'b0001);
        join
        check_value("start bit width", 32'(start_low_bits(sent[0]) * BIT_CYCLES), 32'(low));
        bus_write(ADDR_DATA, {24'h0, sent[1]}, 4'b0001);
        bus_write(ADDR_DATA, {24'h0, sent[2]}, 4'b0001);
        for (int i = 0; i < 3; i++) begin
            wait_rx_ready();
            bus_read(ADDR_DATA, 4'b0001, rd);
            check_value("loopback data", {24'h0, sent[i]}, rd);
        end
        bus_read(ADDR_STATUS, 4'b0001, rd);
        check_value("status after loopback", 32'd0, rd);
        check_value("tx idle after loopback", 32'd1, 32'(tx_line));

        // interrupts enabled then masked
        exp = 32'((1 << INT_RX_READY) | (1 << INT_TX_EMPTY));
        bus_write(ADDR_INT_PEND, exp, 4'b0001);     // drop events from the loopback
        bus_read(ADDR_INT_PEND, 4'b0001, rd);
        check_value("pend cleared", 32'd0, rd);
        bus_write(ADDR_INT_EN, exp, 4'b0001);
        check_value("irq before event", 32'd0, 32'(irq));
        next_byte(b);
        bus_write(ADDR_DATA, {24'h0, b}, 4'b0001);
        wait_rx_ready();
        check_value("irq enabled", 32'd1, 32'(irq));
        bus_read(ADDR_INT_PEND, 4'b0001, rd);
        check_value("pend both", exp, rd);
        bus_write(ADDR_INT_PEND, exp, 4'b0001);
        check_value("irq after clear", 32'd0, 32'(irq));
        bus_read(ADDR_INT_PEND, 4'b0001, rd);
        check_value("pend after clear", 32'd0, rd);
        bus_read(ADDR_DATA, 4'b0001, rd);
        check_value("irq byte", {24'h0, b}, rd);
        bus_write(ADDR_INT_EN, 32'd0, 4'b0001);
        next_byte(b);
        bus_write(ADDR_DATA, {24'h0, b}, 4'b0001);
        wait_rx_ready();
        check_value("irq masked", 32'd0, 32'(irq));
        bus_read(ADDR_INT_PEND, 4'b0001, rd);
        check_value("pend masked", exp, rd);
        bus_read(ADDR_DATA, 4'b0001, rd);
        check_value("masked byte", {24'h0, b}, rd);
        bus_write(ADDR_INT_PEND, exp, 4'b0001);

        // burst with one byte in the serializer and the rest in the tx fifo
        n_accept = (N_BURST < FIFO_DEPTH + 1) ? N_BURST : FIFO_DEPTH + 1;
        n_kept   = (n_accept < FIFO_DEPTH) ? n_accept : FIFO_DEPTH;
        sent.delete();
        t0 = $time;
        for (int i = 0; i < N_BURST; i++) begin
            next_byte(b);
            sent.push_back(b);
            bus_write(ADDR_DATA, {24'h0, b}, 4'b0001);
        end
        bus_read(ADDR_STATUS, 4'b0001, rd);
        check_value("burst within one frame", 32'd1,
                    32'(($time - t0) < FRAME_CYCLES * CLK_PERIOD));
        check_value("status tx full", 32'(n_accept - 1 == FIFO_DEPTH), 32'(rd[1]));
        wait_line_quiet(12 * BIT_CYCLES);
        exp    = 32'd0;
        exp[2] = (n_accept > FIFO_DEPTH);
        exp[0] = (n_kept > 0);
        bus_read(ADDR_STATUS, 4'b0001, rd);
        check_value("status overrun", exp, rd);
        for (int i = 0; i < n_kept; i++) begin
            bus_read(ADDR_DATA, 4'b0001, rd);
            check_value("burst data", {24'h0, sent[i]}, rd);
        end
        bus_read(ADDR_STATUS, 4'b0001, rd);
        check_value("status overrun cleared", 32'd0, rd);
        bus_read(ADDR_DATA, 4'b0001, rd);
        check_value("data read when empty", 32'd0, rd);

        $display("Testbench passed");
        $finish;
    end

endmodule

//--- list.f
uart_pkg.sv
uart_fifo.sv
uart_tx.sv
uart_rx.sv
uart_bus_ctrl.sv
uart_periph.sv
tb_uart_periph.sv

//--- run.sh
#!/usr/bin/env bash
# build with verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_uart_periph -f list.f -o tb_sim \
    && ./obj_dir/tb_sim | tee /dev/stderr | grep -qx "Testbench passed" \
    && echo "simulation PASSED" \
    || { echo "simulation FAILED"; exit 1; }
